//--- include/rv_core_defines.svh
// Widths and reset constants shared by the core and its testbench.
// PC and bus address are 16 bits wide; higher address bits do not exist.
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data word width.
`define RV_XLEN 32

// Bus address and PC width.
`define RV_ADDR_W 16

// General register count.
`define RV_NUM_REGS 32

// First fetch address after reset.
`define RV_BOOT_PC 16'h4000

// Sequential PC increment.
`define RV_PC_STEP 4

`endif

//--- design/rv_isa_pkg.sv
// RV32I instruction-set types; only the subset the core executes.
`include "rv_core_defines.svh"

package rv_isa_pkg;

  // Major opcodes, instr[6:0].
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  // Register index field.
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  typedef logic [2:0] funct3_t;

  // Branch conditions, encoded as the branch funct3.
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_cond_e;

  // Access size, the low two bits of load/store funct3.
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  typedef logic [`RV_XLEN-1:0] instr_t;

endpackage

//--- design/rv_core_pkg.sv
// Microarchitecture types of the multicycle core.
`include "rv_core_defines.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_ADDR_W-1:0] addr_t;

  // Active-high, one bit per byte lane.
  typedef logic [`RV_XLEN/8-1:0] byte_en_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    cls_upper, cls_jump, cls_jump_reg, cls_branch,
    cls_load, cls_store, cls_alu, cls_system
  } instr_class_e;

  typedef enum logic [2:0] {
    st_fetch_req, st_fetch_wait, st_execute, st_mem_req,
    st_mem_wait, st_writeback, st_halted, st_error
  } core_state_e;

endpackage

//--- design/instr_decoder.sv
// Combinational decode; funct fields are read here and nowhere else.
// Any system opcode halts, so ecall and ebreak are not told apart.
`timescale 1ns/10ps

module instr_decoder
(
  input  rv_isa_pkg::instr_t          instr,
  output rv_isa_pkg::reg_idx_t        rs1,
  output rv_isa_pkg::reg_idx_t        rs2,
  output rv_isa_pkg::reg_idx_t        rd,
  output rv_core_pkg::word_t          imm,
  output rv_core_pkg::instr_class_e   instr_class,
  output rv_core_pkg::alu_op_e        alu_op,
  output logic                        use_imm,
  output rv_isa_pkg::branch_cond_e    branch_cond,
  output rv_isa_pkg::mem_size_e       mem_size,
  output logic                        mem_unsigned,
  output logic                        rd_valid,
  output logic                        decode_illegal
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_e opcode;
  funct3_t funct3;
  logic    funct7_5;
  alu_op_e arith_op;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;

  assign opcode   = opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign branch_cond  = branch_cond_e'(funct3);
  assign mem_size     = mem_size_e'(funct3[1:0]);
  assign mem_unsigned = funct3[2];

  // Same funct3 map for register and immediate forms.
  always_comb
  begin
    case (funct3)
      3'b000: arith_op = (opcode == opc_op && funct7_5) ? alu_sub : alu_add;
      3'b001: arith_op = alu_sll;
      3'b010: arith_op = alu_slt;
      3'b011: arith_op = alu_sltu;
      3'b100: arith_op = alu_xor;
      3'b101: arith_op = funct7_5 ? alu_sra : alu_srl;
      3'b110: arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb
  begin
    instr_class    = cls_system;
    alu_op         = alu_add;
    use_imm        = 1'b1;
    imm            = imm_i;
    rd_valid       = 1'b0;
    decode_illegal = 1'b0;
    case (opcode)
      opc_lui, opc_auipc:
      begin
        // Immediate passes through; the PC is added in control for auipc.
        instr_class = cls_upper;
        alu_op      = alu_pass_b;
        imm         = imm_u;
        rd_valid    = 1'b1;
      end
      opc_jal:
      begin
        instr_class = cls_jump;
        imm         = imm_j;
        rd_valid    = 1'b1;
      end
      opc_jalr:
      begin
        instr_class = cls_jump_reg;
        rd_valid    = 1'b1;
      end
      opc_branch:
      begin
        instr_class = cls_branch;
        imm         = imm_b;
        use_imm     = 1'b0;
      end
      opc_load:
      begin
        instr_class = cls_load;
        rd_valid    = 1'b1;
      end
      opc_store:
      begin
        instr_class = cls_store;
        imm         = imm_s;
      end
      opc_op_imm:
      begin
        instr_class = cls_alu;
        alu_op      = arith_op;
        rd_valid    = 1'b1;
      end
      opc_op:
      begin
        instr_class = cls_alu;
        alu_op      = arith_op;
        use_imm     = 1'b0;
        rd_valid    = 1'b1;
      end
      opc_system: instr_class = cls_system;
      default: decode_illegal = 1'b1;
    endcase
  end

endmodule

//--- design/reg_file.sv
// Two combinational read ports, one synchronous write port.
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module reg_file
(
  input  logic                  raw_clk,
  input  logic                  button_reset,
  input  rv_isa_pkg::reg_idx_t  rs1,
  input  rv_isa_pkg::reg_idx_t  rs2,
  input  rv_isa_pkg::reg_idx_t  rd,
  input  logic                  rd_write,
  input  rv_core_pkg::word_t    rd_data,
  output rv_core_pkg::word_t    rs1_data,
  output rv_core_pkg::word_t    rs2_data
);
  import rv_core_pkg::*;

  word_t regs [`RV_NUM_REGS];

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      for (int i = 0; i < `RV_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (rd_write && rd != '0)
      regs[rd] <= rd_data;
  end

  // x0 reads zero.
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- design/exec_alu.sv
// Shift amounts come from the low 5 bits of the second operand.
`timescale 1ns/10ps

module exec_alu
(
  input  rv_core_pkg::word_t        a,
  input  rv_core_pkg::word_t        rs2_data,
  input  rv_core_pkg::word_t        imm,
  input  logic                      use_imm,
  input  rv_core_pkg::alu_op_e      alu_op,
  input  rv_isa_pkg::branch_cond_e  branch_cond,
  output rv_core_pkg::word_t        alu_result,
  output logic                      branch_taken
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  word_t      b;
  logic [4:0] shamt;

  // sltiu sees the sign-extended immediate as unsigned.
  assign b     = use_imm ? imm : rs2_data;
  assign shamt = b[4:0];

  always_comb
  begin
    case (alu_op)
      alu_add:  alu_result = a + b;
      alu_sub:  alu_result = a - b;
      alu_sll:  alu_result = a << shamt;
      alu_slt:  alu_result = word_t'($signed(a) < $signed(b));
      alu_sltu: alu_result = word_t'(a < b);
      alu_xor:  alu_result = a ^ b;
      alu_srl:  alu_result = a >> shamt;
      alu_sra:  alu_result = word_t'($signed(a) >>> shamt);
      alu_or:   alu_result = a | b;
      alu_and:  alu_result = a & b;
      default:  alu_result = b;
    endcase
  end

  // Branches always compare the two registers.
  always_comb
  begin
    case (branch_cond)
      br_eq:   branch_taken = (a == rs2_data);
      br_ne:   branch_taken = (a != rs2_data);
      br_lt:   branch_taken = ($signed(a) < $signed(rs2_data));
      br_ge:   branch_taken = ($signed(a) >= $signed(rs2_data));
      br_ltu:  branch_taken = (a < rs2_data);
      br_geu:  branch_taken = (a >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

//--- design/load_store_unit.sv
// Lane steering for loads and stores; accesses are assumed naturally aligned.
`timescale 1ns/10ps

module load_store_unit
(
  input  logic [1:0]             ea_low,
  input  rv_isa_pkg::mem_size_e  mem_size,
  input  logic                   mem_unsigned,
  input  rv_core_pkg::word_t     rs2_data,
  input  rv_core_pkg::word_t     mem_rdata,
  output rv_core_pkg::word_t     store_data,
  output rv_core_pkg::byte_en_t  store_be,
  output rv_core_pkg::word_t     load_data
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  word_t rdata_shifted;
  logic  ext_bit;

  // Store value copied to every lane; the enables pick the one written.
  always_comb
  begin
    case (mem_size)
      size_byte:
      begin
        store_data = {4{rs2_data[7:0]}};
        store_be   = byte_en_t'(4'b0001 << ea_low);
      end
      size_half:
      begin
        store_data = {2{rs2_data[15:0]}};
        store_be   = ea_low[1] ? 4'b1100 : 4'b0011;
      end
      default:
      begin
        store_data = rs2_data;
        store_be   = 4'b1111;
      end
    endcase
  end

  // Addressed lane moved down to bit 0.
  assign rdata_shifted = mem_rdata >> {ea_low, 3'b000};

  always_comb
  begin
    case (mem_size)
      size_byte:
      begin
        ext_bit   = rdata_shifted[7] & ~mem_unsigned;
        load_data = {{24{ext_bit}}, rdata_shifted[7:0]};
      end
      size_half:
      begin
        ext_bit   = rdata_shifted[15] & ~mem_unsigned;
        load_data = {{16{ext_bit}}, rdata_shifted[15:0]};
      end
      default:
      begin
        ext_bit   = 1'b0;
        load_data = mem_rdata;
      end
    endcase
  end

endmodule

//--- design/core_control.sv
// Multicycle FSM and four-phase req/ack master; one instruction in flight.
// Data accesses use a word address with lane enables; halted and illegal are sticky.
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module core_control
(
  input  logic                       raw_clk,
  input  logic                       button_reset,
  input  logic                       mem_ack,
  input  rv_core_pkg::word_t         mem_rdata,
  input  rv_core_pkg::instr_class_e  instr_class,
  input  rv_core_pkg::word_t         imm,
  input  logic                       rd_valid,
  input  logic                       decode_illegal,
  input  rv_core_pkg::word_t         rs1_data,
  input  rv_core_pkg::word_t         alu_result,
  input  logic                       branch_taken,
  input  rv_core_pkg::word_t         load_data,
  input  rv_core_pkg::word_t         store_data,
  input  rv_core_pkg::byte_en_t      store_be,
  output rv_isa_pkg::instr_t         instr,
  output logic                       rd_write,
  output rv_core_pkg::word_t         rd_data,
  output logic [1:0]                 ea_low,
  output logic                       mem_req,
  output rv_core_pkg::addr_t         mem_addr,
  output logic                       mem_we,
  output rv_core_pkg::byte_en_t      mem_be,
  output rv_core_pkg::word_t         mem_wdata,
  output logic                       halted,
  output logic                       illegal
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  core_state_e state;
  addr_t       pc;
  addr_t       pc_cur;
  addr_t       pc_seq;
  addr_t       ea_q;
  word_t       pc_word;
  word_t       link;
  word_t       jalr_sum;
  word_t       result_q;
  logic        bus_done;
  logic        bus_idle;

  assign pc_seq   = pc_cur + addr_t'(`RV_PC_STEP);
  assign pc_word  = {{(`RV_XLEN - `RV_ADDR_W){1'b0}}, pc_cur};
  assign link     = pc_word + word_t'(`RV_PC_STEP);
  assign jalr_sum = rs1_data + imm;

  // Ack seen while requesting, then both low again.
  assign bus_done = mem_req & mem_ack;
  assign bus_idle = ~mem_req & ~mem_ack;

  assign ea_low   = ea_q[1:0];
  assign rd_data  = result_q;
  assign rd_write = (state == st_writeback) && rd_valid;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state   <= st_fetch_req;
      pc      <= `RV_BOOT_PC;
      mem_req <= 1'b0;
      mem_we  <= 1'b0;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end
    else
    begin
      case (state)
        st_fetch_req:
        begin
          mem_req  <= 1'b1;
          mem_we   <= 1'b0;
          mem_addr <= pc;
          mem_be   <= '1;
          pc_cur   <= pc;
          state    <= st_fetch_wait;
        end
        st_fetch_wait:
        begin
          if (bus_done)
          begin
            instr   <= mem_rdata;
            mem_req <= 1'b0;
          end
          else if (bus_idle)
            state <= st_execute;
        end
        st_execute:
        begin
          pc    <= pc_seq;
          state <= st_writeback;
          if (decode_illegal)
          begin
            illegal <= 1'b1;
            state   <= st_error;
          end
          else
          begin
            case (instr_class)
              cls_upper:
                result_q <= (instr[6:0] == opc_auipc) ? pc_word + alu_result : alu_result;
              cls_jump:
              begin
                pc       <= pc_cur + imm[`RV_ADDR_W-1:0];
                result_q <= link;
              end
              cls_jump_reg:
              begin
                // Target forced to a word boundary.
                pc       <= {jalr_sum[`RV_ADDR_W-1:2], 2'b00};
                result_q <= link;
              end
              cls_branch:
                if (branch_taken)
                  pc <= pc_cur + imm[`RV_ADDR_W-1:0];
              cls_load, cls_store:
              begin
                ea_q  <= alu_result[`RV_ADDR_W-1:0];
                state <= st_mem_req;
              end
              cls_alu: result_q <= alu_result;
              default:
              begin
                halted <= 1'b1;
                state  <= st_halted;
              end
            endcase
          end
        end
        st_mem_req:
        begin
          mem_req   <= 1'b1;
          mem_we    <= (instr_class == cls_store);
          mem_addr  <= {ea_q[`RV_ADDR_W-1:2], 2'b00};
          mem_be    <= store_be;
          mem_wdata <= store_data;
          state     <= st_mem_wait;
        end
        st_mem_wait:
        begin
          if (bus_done)
          begin
            // Read data only valid with ack; a store never writes it back.
            result_q <= load_data;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
          end
          else if (bus_idle)
            state <= st_writeback;
        end
        st_writeback: state <= st_fetch_req;
        st_halted: state <= st_halted;
        default: state <= st_error;
      endcase
    end
  end

endmodule

//--- design/rv_core_top.sv
// RV32I-subset core with an external four-phase req/ack memory bus.
`timescale 1ns/10ps

module rv_core_top
(
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  logic                   mem_ack,
  input  rv_core_pkg::word_t     mem_rdata,
  output logic                   mem_req,
  output rv_core_pkg::addr_t     mem_addr,
  output logic                   mem_we,
  output rv_core_pkg::byte_en_t  mem_be,
  output rv_core_pkg::word_t     mem_wdata,
  output logic                   halted,
  output logic                   illegal
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  instr_t       instr;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  reg_idx_t     rd;
  word_t        imm;
  instr_class_e instr_class;
  alu_op_e      alu_op;
  logic         use_imm;
  branch_cond_e branch_cond;
  mem_size_e    mem_size;
  logic         mem_unsigned;
  logic         rd_valid;
  logic         decode_illegal;
  word_t        rs1_data;
  word_t        rs2_data;
  word_t        alu_result;
  logic         branch_taken;
  logic         rd_write;
  word_t        rd_data;
  logic [1:0]   ea_low;
  word_t        store_data;
  byte_en_t     store_be;
  word_t        load_data;

  core_control i_control (
    .raw_clk, .button_reset, .mem_ack, .mem_rdata, .instr_class, .imm, .rd_valid,
    .decode_illegal, .rs1_data, .alu_result, .branch_taken, .load_data, .store_data,
    .store_be, .instr, .rd_write, .rd_data, .ea_low, .mem_req, .mem_addr, .mem_we,
    .mem_be, .mem_wdata, .halted, .illegal
  );

  instr_decoder i_decoder (
    .instr, .rs1, .rs2, .rd, .imm, .instr_class, .alu_op, .use_imm, .branch_cond,
    .mem_size, .mem_unsigned, .rd_valid, .decode_illegal
  );

  reg_file i_regs (
    .raw_clk, .button_reset, .rs1, .rs2, .rd, .rd_write, .rd_data, .rs1_data, .rs2_data
  );

  exec_alu i_alu (
    .a(rs1_data), .rs2_data, .imm, .use_imm, .alu_op, .branch_cond, .alu_result,
    .branch_taken
  );

  load_store_unit i_lsu (
    .ea_low, .mem_size, .mem_unsigned, .rs2_data, .mem_rdata, .store_data, .store_be,
    .load_data
  );

endmodule

//--- bench/rv_core_tb.sv
// Random program run twice, ending once in ebreak and once in an illegal opcode.
// Every bus request is compared with a transaction list predicted by an ISA model.
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_core_tb;

  localparam int MEM_WORDS = 16384;
  localparam int PROG_OPS  = 60;
  localparam int MAX_DELAY = 5;

  logic                    raw_clk;
  logic                    button_reset;
  logic                    mem_ack;
  logic [`RV_XLEN-1:0]     mem_rdata;
  logic                    mem_req;
  logic [`RV_ADDR_W-1:0]   mem_addr;
  logic                    mem_we;
  logic [3:0]              mem_be;
  logic [`RV_XLEN-1:0]     mem_wdata;
  logic                    halted;
  logic                    illegal;

  logic [31:0] dut_mem   [0:MEM_WORDS-1];
  logic [31:0] model_mem [0:MEM_WORDS-1];
  logic [52:0] exp_q [$];
  logic [52:0] prev_bus;
  logic        prev_req;
  logic        prev_ack;
  logic        run_active;
  logic        pending;
  int          delay;
  longint      deadline;

  rv_core_top i_dut (
    .raw_clk, .button_reset, .mem_ack, .mem_rdata, .mem_req, .mem_addr, .mem_we,
    .mem_be, .mem_wdata, .halted, .illegal
  );

  initial
  begin
    raw_clk = 1'b0;
    forever #5 raw_clk = ~raw_clk;
  end

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic value_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic protocol_fail(input string msg);
    $display("Bus protocol problem: %s", msg);
    stop_run();
  endtask

  // Instruction encoders.
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // Background pattern; mixes every address bit.
  function automatic logic [31:0] fill_word(input logic [15:0] a);
    return ({16'h0, a} * 32'h9e3779b1) ^ {~a, a};
  endfunction

  function automatic logic [3:0] lane_be(input logic [1:0] size, input logic [1:0] lane);
    case (size)
      2'b00: return 4'b0001 << lane;
      2'b01: return lane[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic is_reg, input logic [31:0] a,
                                          input logic [31:0] b);
    case (f3)
      3'd0: return (is_reg && alt) ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'h0, $signed(a) < $signed(b)};
      3'd3: return {31'h0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] rand_op_imm();
    logic [2:0]  f3;
    logic [11:0] imm;
    f3 = 3'($urandom % 8);
    if (f3 == 3'd1)
      imm = {7'h00, 5'($urandom)};
    else if (f3 == 3'd5)
      imm = {1'b0, 1'($urandom % 2), 5'h00, 5'($urandom)};
    else
      imm = 12'($urandom);
    return enc_i(imm, 5'($urandom % 32), f3, 5'($urandom % 31), 7'h13);
  endfunction

  task automatic emit(inout int p, input logic [31:0] w);
    dut_mem[p]   = w;
    model_mem[p] = w;
    p++;
  endtask

  // x31 holds the data base 0x6000 and is never a destination.
  task automatic build_program(input bit end_illegal);
    int         p;
    int         idx;
    logic [1:0] size;
    logic [2:0] f3;
    logic [4:0] rx;
    logic [11:0] off;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      dut_mem[i]   = fill_word(16'(i * 4));
      model_mem[i] = fill_word(16'(i * 4));
    end
    p = `RV_BOOT_PC / 4;
    emit(p, {20'h00006, 5'd31, 7'h37});
    for (int n = 0; n < PROG_OPS; n++)
    begin
      case ($urandom % 9)
        0: emit(p, {20'($urandom), 5'($urandom % 31), 7'h37});
        1: emit(p, {20'($urandom), 5'($urandom % 31), 7'h17});
        2: emit(p, rand_op_imm());
        3:
        begin
          f3 = 3'($urandom % 8);
          emit(p, enc_r(((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1)) ? 7'h20 : 7'h00,
                        5'($urandom % 32), 5'($urandom % 32), f3, 5'($urandom % 31)));
        end
        4:
        begin
          idx = int'($urandom % 6);
          f3  = (idx < 2) ? 3'(idx) : 3'(idx + 2);
          emit(p, enc_b(13'd8, 5'($urandom % 32), 5'($urandom % 32), f3));
          emit(p, rand_op_imm());
        end
        5:
        begin
          emit(p, enc_j(21'd8, 5'($urandom % 31)));
          emit(p, rand_op_imm());
        end
        6:
        begin
          rx = 5'(1 + $urandom % 30);
          emit(p, {20'h00000, rx, 7'h17});
          emit(p, enc_i(12'(12 + $urandom % 4), rx, 3'b000, 5'($urandom % 31), 7'h67));
          emit(p, rand_op_imm());
        end
        default:
        begin
          size = 2'($urandom % 3);
          off  = 12'(($urandom % 64) * 4);
          if (size == 2'b00)
            off = off + 12'($urandom % 4);
          else if (size == 2'b01)
            off = off + 12'(($urandom % 2) * 2);
          if ($urandom % 2 == 1)
            emit(p, enc_s(off, 5'($urandom % 32), 5'd31, {1'b0, size}));
          else
            emit(p, enc_i(off, 5'd31, {(size != 2'b10) && ($urandom % 2 == 1), size},
                          5'($urandom % 31), 7'h03));
        end
      endcase
    end
    for (int r = 0; r < 32; r++)
      emit(p, enc_s(12'(256 + 4 * r), 5'(r), 5'd31, 3'b010));
    emit(p, end_illegal ? 32'h0000007f : 32'h00100073);
  endtask

  // ISA model; fills exp_q with every bus transaction the core must issue.
  task automatic run_model(output int steps, output bit ends_illegal);
    logic [31:0] x [32];
    logic [31:0] ins, a, b, val, t, w, sh, ii, si, bi, ui, ji;
    logic [15:0] pc, npc, ea;
    logic [3:0]  be;
    logic [2:0]  f3;
    bit          wr;
    bit          done;
    bit          take;
    for (int r = 0; r < 32; r++)
      x[r] = 32'h0;
    pc = `RV_BOOT_PC;
    steps = 0;
    done = 0;
    ends_illegal = 0;
    exp_q.delete();
    while (!done && steps < 4000)
    begin
      exp_q.push_back({pc, 1'b0, 4'hf, 32'h0});
      ins = model_mem[pc[15:2]];
      steps++;
      f3 = ins[14:12];
      a  = x[ins[19:15]];
      b  = x[ins[24:20]];
      ii = {{20{ins[31]}}, ins[31:20]};
      si = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      bi = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      ui = {ins[31:12], 12'h000};
      ji = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      npc = pc + 16'(`RV_PC_STEP);
      wr  = 1;
      val = 32'h0;
      case (ins[6:0])
        7'h37: val = ui;
        7'h17: val = {16'h0, pc} + ui;
        7'h6f:
        begin
          val = {16'h0, pc} + 32'd4;
          npc = pc + ji[15:0];
        end
        7'h67:
        begin
          t   = a + ii;
          val = {16'h0, pc} + 32'd4;
          npc = {t[15:2], 2'b00};
        end
        7'h63:
        begin
          wr = 0;
          case (f3)
            3'd0: take = (a == b);
            3'd1: take = (a != b);
            3'd4: take = ($signed(a) < $signed(b));
            3'd5: take = ($signed(a) >= $signed(b));
            3'd6: take = (a < b);
            default: take = (a >= b);
          endcase
          if (take)
            npc = pc + bi[15:0];
        end
        7'h03:
        begin
          t  = a + ii;
          ea = t[15:0];
          be = lane_be(f3[1:0], ea[1:0]);
          exp_q.push_back({ea[15:2], 2'b00, 1'b0, be, 32'h0});
          w  = model_mem[ea[15:2]];
          sh = w >> {ea[1:0], 3'b000};
          case (f3)
            3'd0: val = {{24{sh[7]}}, sh[7:0]};
            3'd1: val = {{16{sh[15]}}, sh[15:0]};
            3'd4: val = {24'h0, sh[7:0]};
            3'd5: val = {16'h0, sh[15:0]};
            default: val = w;
          endcase
        end
        7'h23:
        begin
          wr = 0;
          t  = a + si;
          ea = t[15:0];
          be = lane_be(f3[1:0], ea[1:0]);
          w  = (f3 == 3'd0) ? {4{b[7:0]}} : (f3 == 3'd1) ? {2{b[15:0]}} : b;
          exp_q.push_back({ea[15:2], 2'b00, 1'b1, be, w});
          for (int k = 0; k < 4; k++)
            if (be[k])
              model_mem[ea[15:2]][8*k +: 8] = w[8*k +: 8];
        end
        7'h13: val = alu_ref(f3, ins[30], 1'b0, a, ii);
        7'h33: val = alu_ref(f3, ins[30], 1'b1, a, b);
        7'h73: done = 1;
        default:
        begin
          done = 1;
          ends_illegal = 1;
        end
      endcase
      if (!done && wr && ins[11:7] != 5'd0)
        x[ins[11:7]] = val;
      pc = npc;
    end
  endtask

  // Memory responder with a random ack delay.
  always @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      mem_ack <= 1'b0;
      pending <= 1'b0;
    end
    else if (mem_ack)
    begin
      if (!mem_req)
        mem_ack <= 1'b0;
    end
    else if (mem_req)
    begin
      if (!pending)
      begin
        pending <= 1'b1;
        delay   <= int'($urandom % (MAX_DELAY + 1));
      end
      else if (delay != 0)
        delay <= delay - 1;
      else
      begin
        pending <= 1'b0;
        mem_ack <= 1'b1;
        if (mem_we)
        begin
          for (int k = 0; k < 4; k++)
            if (mem_be[k])
              dut_mem[mem_addr[15:2]][8*k +: 8] = mem_wdata[8*k +: 8];
        end
        else
          mem_rdata <= dut_mem[mem_addr[15:2]];
      end
    end
  end

  // Bus monitor sampled mid-cycle.
  always @(negedge raw_clk)
  begin
    if (button_reset && run_active)
    begin
      if (mem_req && !prev_req)
      begin
        assert (!mem_ack)
        else protocol_fail("request raised while acknowledge was still high");
        assert (exp_q.size() != 0)
        else protocol_fail("request issued after the program should have stopped");
        assert ({mem_addr, mem_we, mem_be, mem_we ? mem_wdata : 32'h0} == exp_q[0])
        else value_error($sformatf("bus request addr=%h we=%b be=%b wdata=%h, expected %h",
                                   mem_addr, mem_we, mem_be, mem_wdata, exp_q[0]));
        void'(exp_q.pop_front());
      end
      else if (mem_req && prev_req && !prev_ack)
      begin
        assert ({mem_addr, mem_we, mem_be, mem_wdata} == prev_bus)
        else protocol_fail("request outputs changed before acknowledge");
      end
    end
    prev_req = mem_req;
    prev_ack = mem_ack;
    prev_bus = {mem_addr, mem_we, mem_be, mem_wdata};
  end

  // Watchdog against the deadline of the current run.
  initial
  begin
    forever
    begin
      @(posedge raw_clk);
      if (run_active && $time > deadline)
      begin
        $display("Timeout: core did not halt within the allowed number of cycles");
        stop_run();
      end
    end
  end

  task automatic run_program(input bit end_illegal);
    int steps;
    bit exp_ill;
    build_program(end_illegal);
    run_model(steps, exp_ill);
    run_active = 1'b0;
    @(posedge raw_clk);
    button_reset <= 1'b0;
    repeat (3) @(posedge raw_clk);
    button_reset <= 1'b1;
    deadline   = $time + longint'(steps * (40 + MAX_DELAY) + 40) * 10;
    run_active = 1'b1;
    @(negedge raw_clk);
    assert (!mem_req && !halted && !illegal)
    else value_error("req, halted or illegal high right after reset");
    while (!(halted || illegal))
      @(negedge raw_clk);
    assert (illegal == exp_ill && halted == !exp_ill)
    else value_error($sformatf("halted=%b illegal=%b, expected illegal=%b",
                               halted, illegal, exp_ill));
    repeat (10) @(negedge raw_clk);
    assert (exp_q.size() == 0)
    else value_error($sformatf("%0d expected bus requests never issued", exp_q.size()));
    run_active = 1'b0;
  endtask

  initial
  begin
    void'($urandom(32'hc8eb));
    button_reset <= 1'b0;
    mem_ack      <= 1'b0;
    mem_rdata    <= 32'h0;
    run_active   = 1'b0;
    deadline     = 0;
    run_program(1'b0);
    run_program(1'b1);
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+include
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/exec_alu.sv
design/load_store_unit.sv
design/core_control.sv
design/rv_core_top.sv
bench/rv_core_tb.sv

//--- run_sim.sh
#!/bin/bash
# Builds the core and testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
  && ./obj_dir/rv_core_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^NO ERRORS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
